/* logic/fetch_pkg.sv */
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////
    // fetch path widths

    localparam int ADDR_W     = 32;
    localparam int LINE_OFF_W = 4;    // 16 bytes per line
    localparam int LINE_W     = 128;

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [ADDR_W-LINE_OFF_W-1:0] line_addr_t;  // byte address >> 4
    typedef logic [LINE_W-1:0]            line_t;

    // bank identity
    typedef logic bank_sel_t;

    localparam bank_sel_t BANK_EVEN = 1'b0;
    localparam bank_sel_t BANK_ODD  = 1'b1;

endpackage

/* logic/bus_pkg.sv */
package bus_pkg;

    ////////////////////////////////////////////////////////////////////
    // memory port

    // names the requesting bank, echoed back on the response
    typedef logic mem_tag_t;

    localparam int CREDIT_W = 4;

    typedef logic [CREDIT_W-1:0] credit_cnt_t;  // credits held by the arbiter

endpackage

/* logic/fill_if.sv */
`timescale 1ns/10ps

interface fill_if;
    import fetch_pkg::*;

    // request side, held until grant
    logic       req_valid;
    line_addr_t req_line;
    logic       grant;

    // one cycle fill pulse
    logic       rsp_valid;
    line_t      rsp_line;

    modport bank (
        output req_valid,
        output req_line,
        input  grant,
        input  rsp_valid,
        input  rsp_line
    );

    modport arbiter (
        input  req_valid,
        input  req_line,
        output grant,
        output rsp_valid,
        output rsp_line
    );

endinterface

/* logic/fip_select.sv */
`timescale 1ns/10ps

module fip_select (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  init_i,
    input  fetch_pkg::addr_t      init_addr_i,
    input  logic                  resteer_i,
    input  fetch_pkg::addr_t      resteer_addr_i,
    input  logic                  bp_taken_i,
    input  fetch_pkg::addr_t      bp_addr_i,
    input  logic                  advance_i,
    output fetch_pkg::line_addr_t fip_even_o,
    output fetch_pkg::line_addr_t fip_odd_o
);
    import fetch_pkg::*;

    logic       redirect;
    addr_t      cf_addr;
    line_addr_t cf_line;
    line_addr_t cf_line_p1;

    ////////////////////////////////////////////////////////////////////
    // control flow target, init > resteer > branch prediction

    always_comb begin
        redirect = init_i | resteer_i | bp_taken_i;
        if (init_i) begin
            cf_addr = init_addr_i;
        end else if (resteer_i) begin
            cf_addr = resteer_addr_i;
        end else begin
            cf_addr = bp_addr_i;
        end
    end

    assign cf_line    = cf_addr[ADDR_W-1:LINE_OFF_W];
    assign cf_line_p1 = cf_line + line_addr_t'(1);

    ////////////////////////////////////////////////////////////////////
    // pointer registers

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fip_even_o <= line_addr_t'(0);
            fip_odd_o  <= line_addr_t'(1);
        end else if (redirect) begin
            // target line goes to the bank matching its low bit
            if (cf_line[0]) begin
                fip_even_o <= cf_line_p1;
                fip_odd_o  <= cf_line;
            end else begin
                fip_even_o <= cf_line;
                fip_odd_o  <= cf_line_p1;
            end
        end else if (advance_i) begin
            fip_even_o <= fip_even_o + line_addr_t'(2);  // next window
            fip_odd_o  <= fip_odd_o + line_addr_t'(2);
        end
    end

endmodule

/* logic/icache_bank.sv */
`timescale 1ns/10ps

module icache_bank #(
    parameter int unsigned SETS = 16
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  fetch_pkg::line_addr_t fip_i,
    fill_if.bank                  fill,
    output logic                  hit_o,
    output fetch_pkg::line_t      line_o
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = $bits(line_addr_t) - IDX_W - 1;  // bit 0 fixed per bank

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } bank_state_t;

    bank_state_t state_q;
    bank_state_t state_d;

    line_t      data_mem [SETS];
    tag_t       tag_mem  [SETS];
    logic [SETS-1:0] valid_q;

    idx_t       rd_idx;
    tag_t       rd_tag;
    line_addr_t miss_line_q;   // line being filled
    idx_t       fill_idx;
    tag_t       fill_tag;
    logic       fill_we;

    ////////////////////////////////////////////////////////////////////
    // lookup

    assign rd_idx = fip_i[IDX_W:1];
    assign rd_tag = fip_i[$bits(line_addr_t)-1 -: TAG_W];

    assign hit_o  = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign line_o = data_mem[rd_idx];

    ////////////////////////////////////////////////////////////////////
    // miss FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!hit_o) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (fill.grant) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (fill.rsp_valid) begin
                    state_d = IDLE;  // pointer re-checked from here
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // captured while idle, held through REQ and WAIT
    always_ff @(posedge clk) begin
        if (state_q == IDLE && !hit_o) begin
            miss_line_q <= fip_i;
        end
    end

    assign fill.req_valid = (state_q == REQ);
    assign fill.req_line  = miss_line_q;

    ////////////////////////////////////////////////////////////////////
    // line fill

    assign fill_we  = (state_q == WAIT) && fill.rsp_valid;
    assign fill_idx = miss_line_q[IDX_W:1];
    assign fill_tag = miss_line_q[$bits(line_addr_t)-1 -: TAG_W];

    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[fill_idx] <= fill.rsp_line;
            tag_mem[fill_idx]  <= fill_tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_we) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

endmodule

/* logic/fill_arbiter.sv */
`timescale 1ns/10ps

module fill_arbiter #(
    parameter int unsigned MEM_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    fill_if.arbiter               even_port,
    fill_if.arbiter               odd_port,
    output logic                  mem_req_valid_o,
    output fetch_pkg::line_addr_t mem_req_line_o,
    output bus_pkg::mem_tag_t     mem_req_tag_o,
    input  logic                  mem_credit_i,
    input  logic                  mem_rsp_valid_i,
    input  bus_pkg::mem_tag_t     mem_rsp_tag_i,
    input  fetch_pkg::line_t      mem_rsp_data_i
);
    import fetch_pkg::*;
    import bus_pkg::*;

    credit_cnt_t credit_q;
    bank_sel_t   last_q;     // bank served last
    bank_sel_t   sel;
    logic        have_credit;
    logic        grant_even;
    logic        grant_odd;

    ////////////////////////////////////////////////////////////////////
    // round robin pick

    assign have_credit = (credit_q != credit_cnt_t'(0));

    always_comb begin
        grant_even = 1'b0;
        grant_odd  = 1'b0;
        if (have_credit) begin
            if (even_port.req_valid && odd_port.req_valid) begin
                // both asking, favor the other bank
                grant_odd  = (last_q == BANK_EVEN);
                grant_even = (last_q == BANK_ODD);
            end else begin
                grant_even = even_port.req_valid;
                grant_odd  = odd_port.req_valid;
            end
        end
    end

    assign sel = grant_odd ? BANK_ODD : BANK_EVEN;

    assign even_port.grant = grant_even;
    assign odd_port.grant  = grant_odd;

    assign mem_req_valid_o = grant_even | grant_odd;
    assign mem_req_line_o  = (sel == BANK_ODD) ? odd_port.req_line : even_port.req_line;
    assign mem_req_tag_o   = mem_tag_t'(sel);

    ////////////////////////////////////////////////////////////////////
    // credits and rr state

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_q <= credit_cnt_t'(MEM_CREDITS);
            last_q   <= BANK_ODD;  // even goes first
        end else begin
            case ({mem_req_valid_o, mem_credit_i})
                2'b10:   credit_q <= credit_q - credit_cnt_t'(1);
                2'b01:   credit_q <= credit_q + credit_cnt_t'(1);
                default: credit_q <= credit_q;  // none, or spend and refill
            endcase
            if (mem_req_valid_o) begin
                last_q <= sel;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // response routing by tag

    assign even_port.rsp_valid = mem_rsp_valid_i && (bank_sel_t'(mem_rsp_tag_i) == BANK_EVEN);
    assign odd_port.rsp_valid  = mem_rsp_valid_i && (bank_sel_t'(mem_rsp_tag_i) == BANK_ODD);
    assign even_port.rsp_line  = mem_rsp_data_i;
    assign odd_port.rsp_line   = mem_rsp_data_i;

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top #(
    parameter int unsigned SETS        = 16,
    parameter int unsigned MEM_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  init_i,
    input  fetch_pkg::addr_t      init_addr_i,
    input  logic                  resteer_i,
    input  fetch_pkg::addr_t      resteer_addr_i,
    input  logic                  bp_taken_i,
    input  fetch_pkg::addr_t      bp_addr_i,
    input  logic                  fetch_ready_i,
    output logic                  fetch_valid_o,
    output fetch_pkg::line_addr_t fip_even_o,
    output fetch_pkg::line_addr_t fip_odd_o,
    output fetch_pkg::line_t      line_even_o,
    output fetch_pkg::line_t      line_odd_o,
    // memory port
    output logic                  mem_req_valid_o,
    output fetch_pkg::line_addr_t mem_req_line_o,
    output bus_pkg::mem_tag_t     mem_req_tag_o,
    input  logic                  mem_credit_i,
    input  logic                  mem_rsp_valid_i,
    input  bus_pkg::mem_tag_t     mem_rsp_tag_i,
    input  fetch_pkg::line_t      mem_rsp_data_i
);

    logic hit_even;
    logic hit_odd;
    logic advance;

    fill_if even_fill ();
    fill_if odd_fill ();

    // window valid only when both halves hit
    assign fetch_valid_o = hit_even & hit_odd;
    assign advance       = fetch_valid_o & fetch_ready_i;

    ////////////////////////////////////////////////////////////////////
    // fetch pointers

    fip_select u_fip_select (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .init_i         (init_i),
        .init_addr_i    (init_addr_i),
        .resteer_i      (resteer_i),
        .resteer_addr_i (resteer_addr_i),
        .bp_taken_i     (bp_taken_i),
        .bp_addr_i      (bp_addr_i),
        .advance_i      (advance),
        .fip_even_o     (fip_even_o),
        .fip_odd_o      (fip_odd_o)
    );

    ////////////////////////////////////////////////////////////////////
    // cache banks

    icache_bank #(.SETS(SETS)) bank_even (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .fip_i    (fip_even_o),
        .fill     (even_fill.bank),
        .hit_o    (hit_even),
        .line_o   (line_even_o)
    );

    icache_bank #(.SETS(SETS)) bank_odd (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .fip_i    (fip_odd_o),
        .fill     (odd_fill.bank),
        .hit_o    (hit_odd),
        .line_o   (line_odd_o)
    );

    ////////////////////////////////////////////////////////////////////
    // shared fill path

    fill_arbiter #(.MEM_CREDITS(MEM_CREDITS)) u_fill_arbiter (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .even_port       (even_fill.arbiter),
        .odd_port        (odd_fill.arbiter),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_line_o  (mem_req_line_o),
        .mem_req_tag_o   (mem_req_tag_o),
        .mem_credit_i    (mem_credit_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_tag_i   (mem_rsp_tag_i),
        .mem_rsp_data_i  (mem_rsp_data_i)
    );

endmodule

/* tb/fetch_tb_tests.svh */
    ////////////////////////////////////////////////////////////////////
    // pointer rule and drive helpers

    function automatic line_addr_t ptr_even(input addr_t a);
        line_addr_t l;
        l = a[ADDR_W-1:LINE_OFF_W];
        if (l[0]) begin
            return l + line_addr_t'(1);  // odd target, even half is next line
        end
        return l;
    endfunction

    function automatic line_addr_t ptr_odd(input addr_t a);
        line_addr_t l;
        l = a[ADDR_W-1:LINE_OFF_W];
        if (l[0]) begin
            return l;
        end
        return l + line_addr_t'(1);
    endfunction

    task automatic apply_reset();
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
    endtask

    // kinds is {init, resteer, bp}
    task automatic apply_redirect(input logic [2:0] kinds, input addr_t ia,
                                  input addr_t ra, input addr_t ba);
        @(posedge clk);
        init_i         <= kinds[2];
        resteer_i      <= kinds[1];
        bp_taken_i     <= kinds[0];
        init_addr_i    <= ia;
        resteer_addr_i <= ra;
        bp_addr_i      <= ba;
        @(posedge clk);
        init_i     <= 1'b0;
        resteer_i  <= 1'b0;
        bp_taken_i <= 1'b0;
    endtask

    task automatic init_to(input addr_t a);
        apply_redirect(3'b100, a, '0, '0);
    endtask

    task automatic wait_valid();
        do @(posedge clk); while (!fetch_valid_o);
    endtask

    task automatic check_window(input string name, input line_addr_t e, input line_addr_t o);
        check_fip(name, e, fip_even_o);
        check_fip(name, o, fip_odd_o);
        check_line(name, line_data(e), line_even_o);
        check_line(name, line_data(o), line_odd_o);
    endtask

    task automatic accept_window(input string name, input line_addr_t e, input line_addr_t o);
        fetch_ready_i <= 1'b1;
        do @(posedge clk); while (!fetch_valid_o);
        check_window(name, e, o);  // window taken at this edge
        fetch_ready_i <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_cold_fetch();
        init_to(32'h0000_1200);
        wait_valid();
        check_window("cold_fetch", ptr_even(32'h0000_1200), ptr_odd(32'h0000_1200));
    endtask

    task automatic test_sequential_fetch();
        line_addr_t e;
        line_addr_t o;
        int         reqs_before;
        init_to(32'h0000_2040);
        wait_valid();
        e = ptr_even(32'h0000_2040);
        o = ptr_odd(32'h0000_2040);
        repeat (5) begin  // ready low, window must hold
            @(posedge clk);
            check_window("back_pressure", e, o);
        end
        for (int k = 0; k < 6; k++) begin
            accept_window("sequential", e, o);
            e = e + line_addr_t'(2);
            o = o + line_addr_t'(2);
            wait_valid();
            check_window("sequential_next", e, o);
        end
        @(negedge clk);
        reqs_before = req_total;
        init_to(32'h0000_2040);
        wait_valid();
        check_window("refetch_hit", ptr_even(32'h0000_2040), ptr_odd(32'h0000_2040));
        @(negedge clk);
        check_count("refetch_no_requests", credit_cnt_t'(0),
                    credit_cnt_t'(req_total - reqs_before));
    endtask

    task automatic test_odd_alignment();
        init_to(32'h0000_3310);  // line 0x331
        wait_valid();
        check_window("odd_alignment", line_addr_t'(28'h332), line_addr_t'(28'h331));
    endtask

    task automatic test_redirect_priority();
        apply_redirect(3'b111, 32'h0000_5000, 32'h0000_6010, 32'h0000_7020);
        @(posedge clk);
        check_fip("prio_init_even", ptr_even(32'h0000_5000), fip_even_o);
        check_fip("prio_init_odd", ptr_odd(32'h0000_5000), fip_odd_o);
        apply_redirect(3'b011, '0, 32'h0000_6010, 32'h0000_7020);
        @(posedge clk);
        check_fip("prio_resteer_even", ptr_even(32'h0000_6010), fip_even_o);
        check_fip("prio_resteer_odd", ptr_odd(32'h0000_6010), fip_odd_o);
        apply_redirect(3'b001, '0, '0, 32'h0000_7020);
        @(posedge clk);
        check_fip("prio_bp_even", ptr_even(32'h0000_7020), fip_even_o);
        check_fip("prio_bp_odd", ptr_odd(32'h0000_7020), fip_odd_o);
        wait_valid();
    endtask

    task automatic test_credit_limit();
        addr_t a;
        credit_lag <= 10;  // credits come back late
        do @(negedge clk); while (outstanding != 0);
        @(posedge clk);
        peak_clear <= 1'b1;
        @(posedge clk);
        peak_clear <= 1'b0;
        for (int k = 0; k < 4; k++) begin
            a = 32'h0004_0000 + addr_t'(k) * 32'h40;  // fresh lines in both banks
            init_to(a);
            wait_valid();
            check_window("credit_limit", ptr_even(a), ptr_odd(a));
        end
        @(negedge clk);
        check_count("credit_peak", credit_cnt_t'(MEM_CREDITS), credit_cnt_t'(peak_outstanding));
        credit_lag <= 0;
    endtask

/* tb/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb;
    import fetch_pkg::*;
    import bus_pkg::*;

    localparam int unsigned SETS           = 16;
    localparam int unsigned MEM_CREDITS    = 2;
    // ~15 windows, each up to two fills of 8 cycles plus credit lag, with margin
    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] RAND_SEED      = 32'h2904_407c;

    logic       clk;
    logic       arst_n_i;
    logic       init_i;
    addr_t      init_addr_i;
    logic       resteer_i;
    addr_t      resteer_addr_i;
    logic       bp_taken_i;
    addr_t      bp_addr_i;
    logic       fetch_ready_i;
    logic       fetch_valid_o;
    line_addr_t fip_even_o;
    line_addr_t fip_odd_o;
    line_t      line_even_o;
    line_t      line_odd_o;
    logic       mem_req_valid_o;
    line_addr_t mem_req_line_o;
    mem_tag_t   mem_req_tag_o;
    logic       mem_credit_i    = 1'b0;
    logic       mem_rsp_valid_i = 1'b0;
    mem_tag_t   mem_rsp_tag_i   = '0;
    line_t      mem_rsp_data_i  = '0;

    // memory model state
    line_addr_t pend_line [$];
    mem_tag_t   pend_tag [$];
    int         pend_due [$];
    int         credit_due [$];
    int         cycle            = 0;
    int         held_credits     = int'(MEM_CREDITS);  // arbiter's view of credits
    int         outstanding      = 0;
    int         peak_outstanding = 0;
    int         req_total        = 0;
    int         credit_lag;        // cycles from response to credit
    logic       peak_clear;

    fetch_top #(.SETS(SETS), .MEM_CREDITS(MEM_CREDITS)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // line L is its address, zero extended to 32 bits, four times
    function automatic line_t line_data(input line_addr_t l);
        return {4{32'(l)}};
    endfunction

    task automatic abort_run(input string reason);
        $display("RESULT: FAIL");
        $display("%s", reason);
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            abort_run("line data mismatch");
        end
    endtask

    task automatic check_fip(input string name, input line_addr_t exp, input line_addr_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            abort_run("fetch pointer mismatch");
        end
    endtask

    task automatic check_count(input string name, input credit_cnt_t exp,
                               input credit_cnt_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            abort_run("count mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // memory model with credits

    always @(posedge clk) begin
        int pick;
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            abort_run("the run did not finish within the cycle limit");
        end
        if (peak_clear) begin
            peak_outstanding = outstanding;
        end
        if (mem_req_valid_o) begin  // checked before this edge's credit lands
            if (held_credits == 0) begin
                abort_run("a memory request was issued with no credit held");
            end
            held_credits = held_credits - 1;
            outstanding  = outstanding + 1;
            req_total    = req_total + 1;
            if (outstanding > peak_outstanding) begin
                peak_outstanding = outstanding;
            end
            pend_line.push_back(mem_req_line_o);
            pend_tag.push_back(mem_req_tag_o);
            pend_due.push_back(cycle + int'($urandom_range(8, 1)));
        end
        if (mem_credit_i) begin
            held_credits = held_credits + 1;
            outstanding  = outstanding - 1;
        end
        mem_rsp_valid_i <= 1'b0;
        mem_credit_i    <= 1'b0;
        pick = -1;
        foreach (pend_due[i]) begin
            if (pick < 0 && pend_due[i] <= cycle) begin
                pick = i;  // any ready one, order not kept
            end
        end
        if (pick >= 0) begin
            mem_rsp_valid_i <= 1'b1;
            mem_rsp_tag_i   <= pend_tag[pick];
            mem_rsp_data_i  <= line_data(pend_line[pick]);
            pend_line.delete(pick);
            pend_tag.delete(pick);
            pend_due.delete(pick);
            credit_due.push_back(cycle + credit_lag);
        end
        if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
            mem_credit_i <= 1'b1;
            void'(credit_due.pop_front());
        end
    end

    `include "fetch_tb_tests.svh"

    initial begin
        void'($urandom(RAND_SEED));
        arst_n_i       = 1'b0;
        init_i         = 1'b0;
        init_addr_i    = '0;
        resteer_i      = 1'b0;
        resteer_addr_i = '0;
        bp_taken_i     = 1'b0;
        bp_addr_i      = '0;
        fetch_ready_i  = 1'b0;
        credit_lag     = 0;
        peak_clear     = 1'b0;
        apply_reset();
        test_cold_fetch();
        test_sequential_fetch();
        test_odd_alignment();
        test_redirect_priority();
        test_credit_limit();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* fetch_top.f */
+incdir+tb
logic/fetch_pkg.sv
logic/bus_pkg.sv
logic/fill_if.sv
logic/fip_select.sv
logic/icache_bank.sv
logic/fill_arbiter.sv
logic/fetch_top.sv
tb/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the fetch testbench with Verilator, run it, and scan the log.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f fetch_top.f --top-module fetch_tb \
    -Mdir "$BUILD_DIR" -o fetch_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/fetch_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished without failures"
exit 0
